//--- source/qla_params.svh
// board register bus constants
// address spaces, channel offsets, safety and sampling settings
`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// ---------------------------------------------------------------------------
// address spaces, addr[15:12]
`define ADDR_MAIN       4'h0    // channel registers
`define ADDR_SAMPLE     4'h9    // sampled block-read buffer

// channel offsets, addr[3:0]
`define OFF_STATUS      4'd0    // chan 0 only: disables / clear mask
`define OFF_ADC_DATA    4'd0    // feedback high half, command low half
`define OFF_DAC_CTRL    4'd1    // command readback in low half

// ---------------------------------------------------------------------------
`define NUM_AXES        4
`define SAFETY_MARGIN   16'h0400    // added to 2x command
`define SAFETY_HOLD     4           // exceeding cycles before latch

`define SAMPLE_WORDS    6           // burst length, buffer entries
`define RT_LAST_ADDR    3'd4        // real-time quadlet that carries the mask

`endif

//--- source/qla_pkg.sv
// shared bus types for the board register bus
// address union plus write-bus and real-time write structs
`default_nettype none

`include "qla_params.svh"

package qla_pkg;

    // main register view of a bus address
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] unused;     // always zero from hosts
        logic [3:0] chan;       // 0 board, 1..4 axes
        logic [3:0] offset;
    } reg_main_t;

    // memory view, for buffer spaces
    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] index;
    } reg_mem_t;

    typedef union packed {
        reg_main_t main;
        reg_mem_t  mem;
    } reg_addr_u;

    // register write bus, 49 bits
    typedef struct packed {
        logic      wen;         // single-cycle strobe
        reg_addr_u waddr;
        logic [31:0] wdata;
    } wr_bus_t;

    // real-time block write quadlet, 36 bits
    typedef struct packed {
        logic        wen;
        logic [2:0]  waddr;     // 0..3 commands, 4 mask
        logic [31:0] wdata;
    } rt_wr_t;

    typedef logic [`NUM_AXES-1:0][15:0] axis_word_t;   // one word per axis

endpackage

`default_nettype wire

//--- source/timestamp_counter.sv
// timestamp counter
// cycles since reset or since the last accepted sample start
`timescale 1ns/1ps
`default_nettype none

module timestamp_counter (
    input  wire logic        sysclk,
    input  wire logic        reset,
    input  wire logic        restart,   // accepted sample start
    output logic [31:0]      count
);

    // count holds the delta in the restart cycle, then starts again at 1
    always_ff @(posedge sysclk) begin
        if (reset)
            count <= 32'd0;
        else if (restart)
            count <= 32'd1;
        else
            count <= count + 32'd1;    // wraps, never saturates
    end

endmodule

`default_nettype wire

//--- source/rt_block_writer.sv
// real-time block writer
// stages four axis commands and a mask, then writes them out on the register bus
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module rt_block_writer (
    input  wire logic             sysclk,
    input  wire logic             reset,
    input  wire qla_pkg::rt_wr_t  rt_wr,
    output logic                  bw_active,
    output qla_pkg::wr_bus_t      bw_wr
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t      state;
    logic [1:0]  axis_idx;                  // current axis during write-out
    logic [3:0]  mask;                      // which axes get written
    logic [15:0] cmd_stage [`NUM_AXES];     // staged commands, payload only

    // -----------------------------------------------------------------------
    // staging and write-out sequencing
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= ST_IDLE;
            axis_idx <= 2'd0;
            mask     <= 4'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rt_wr.wen && rt_wr.waddr == `RT_LAST_ADDR) begin
                        mask     <= rt_wr.wdata[3:0];
                        axis_idx <= 2'd0;
                        state    <= ST_WRITE;       // burst starts next cycle
                    end
                end
                ST_WRITE: begin
                    axis_idx <= axis_idx + 2'd1;
                    if (axis_idx == 2'd3)
                        state <= ST_IDLE;           // 4 cycles, back to idle
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command quadlets 0..3 only accepted while idle
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && rt_wr.wen && !rt_wr.waddr[2])
            cmd_stage[rt_wr.waddr[1:0]] <= rt_wr.wdata[15:0];
    end

    // -----------------------------------------------------------------------
    // bus drive, plain register write to the axis DAC offset
    assign bw_active = (state == ST_WRITE);

    always_comb begin
        bw_wr                    = '0;
        bw_wr.wen                = bw_active & mask[axis_idx];   // skip unmasked axes
        bw_wr.waddr.main.space   = `ADDR_MAIN;
        bw_wr.waddr.main.chan    = {2'b00, axis_idx} + 4'd1;     // axis 1..4
        bw_wr.waddr.main.offset  = `OFF_DAC_CTRL;
        bw_wr.wdata              = {16'd0, cmd_stage[axis_idx]};
    end

    // -----------------------------------------------------------------------
    // host side must hold off real-time writes during the burst
    a_no_rt_wr_in_burst: assert property (
        @(posedge sysclk) disable iff (reset)
        bw_active |-> !rt_wr.wen
    ) else $error("real-time write during block write-out");

endmodule

`default_nettype wire

//--- source/sample_sequencer.sv
// sample sequencer for block reads
// takes the read bus for a fixed burst and copies timestamp, axis data and status
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module sample_sequencer (
    input  wire logic               sysclk,
    input  wire logic               reset,
    input  wire logic               sample_start,
    output logic                    sample_busy,
    output qla_pkg::reg_addr_u      sample_raddr,
    input  wire logic [31:0]        reg_rdata,      // combinational read data
    input  wire logic [4:0]         buf_index,
    output logic [31:0]             buf_rdata
);

    logic        start_ok;                      // start accepted this cycle
    logic [2:0]  step;                          // burst position
    logic [31:0] ts_count;
    logic [31:0] ts_hold;                       // delta taken at start
    logic [31:0] sbuf [`SAMPLE_WORDS];
    logic [3:0]  step_chan;

    assign start_ok = sample_start & ~sample_busy;

    timestamp_counter u_timestamp_counter (
        .sysclk  (sysclk),
        .reset   (reset),
        .restart (start_ok),
        .count   (ts_count)
    );

    // -----------------------------------------------------------------------
    // busy window and step counter
    always_ff @(posedge sysclk) begin
        if (reset) begin
            sample_busy <= 1'b0;
            step        <= 3'd0;
        end else if (start_ok) begin
            sample_busy <= 1'b1;
            step        <= 3'd0;
        end else if (sample_busy) begin
            step <= step + 3'd1;
            if (step == 3'(`SAMPLE_WORDS - 1))
                sample_busy <= 1'b0;            // last word this cycle
        end
    end

    always_ff @(posedge sysclk) begin
        if (start_ok)
            ts_hold <= ts_count;
    end

    // steps 1..4 read the axes, everything else reads board status
    assign step_chan = (step >= 3'd1 && step <= 3'(`NUM_AXES)) ? {1'b0, step} : 4'd0;

    always_comb begin
        sample_raddr             = '0;
        sample_raddr.main.space  = `ADDR_MAIN;
        sample_raddr.main.chan   = step_chan;
        sample_raddr.main.offset = `OFF_ADC_DATA;   // same code as status on chan 0
    end

    // -----------------------------------------------------------------------
    // sample buffer
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < `SAMPLE_WORDS; i++)
                sbuf[i] <= 32'd0;
        end else if (sample_busy) begin
            sbuf[step] <= (step == 3'd0) ? ts_hold : reg_rdata;   // entry 0 is the timestamp
        end
    end

    // unused entries read as zero
    assign buf_rdata = (buf_index < 5'(`SAMPLE_WORDS)) ? sbuf[buf_index[2:0]] : 32'd0;

    a_busy_length: assert property (
        @(posedge sysclk) disable iff (reset)
        $rose(sample_busy) |-> ##(`SAMPLE_WORDS) !sample_busy
    ) else $error("sample burst longer than SAMPLE_WORDS");

endmodule

`default_nettype wire

//--- source/axis_regs.sv
// axis channel registers
// DAC commands, registered feedback, safety latches and main-space reads
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module axis_regs (
    input  wire logic                sysclk,
    input  wire logic                reset,
    input  wire qla_pkg::wr_bus_t    wr,
    input  wire qla_pkg::reg_addr_u  raddr,
    output logic [31:0]              rdata,
    input  wire qla_pkg::axis_word_t cur_fb,
    output qla_pkg::axis_word_t      cur_cmd,
    output logic [3:0]               amp_disable
);

    localparam int HOLD_W = $clog2(`SAFETY_HOLD + 1);

    qla_pkg::axis_word_t fb_q;                  // feedback, one cycle late
    logic [HOLD_W-1:0]   exceed_cnt [`NUM_AXES];
    logic [3:0]          exceed;
    logic [3:0]          dis_set;
    logic [3:0]          dis_clr;
    logic                wr_main;
    logic [1:0]          wr_axis;
    logic                wr_axis_ok;
    logic [1:0]          rd_axis;
    logic                rd_axis_ok;

    // -----------------------------------------------------------------------
    // write decode
    assign wr_main    = wr.wen && (wr.waddr.main.space == `ADDR_MAIN);
    assign wr_axis    = 2'(wr.waddr.main.chan - 4'd1);
    assign wr_axis_ok = (wr.waddr.main.chan >= 4'd1) &&
                        (wr.waddr.main.chan <= 4'(`NUM_AXES));

    // status write on chan 0 clears by bit mask
    assign dis_clr = (wr_main && wr.waddr.main.chan == 4'd0 &&
                      wr.waddr.main.offset == `OFF_STATUS) ? wr.wdata[3:0] : 4'd0;

    always_ff @(posedge sysclk) begin
        if (reset)
            cur_cmd <= '0;
        else if (wr_main && wr_axis_ok && wr.waddr.main.offset == `OFF_DAC_CTRL)
            cur_cmd[wr_axis] <= wr.wdata[15:0];
    end

    always_ff @(posedge sysclk) begin
        fb_q <= cur_fb;
    end

    // -----------------------------------------------------------------------
    // safety check, fb > 2*cmd + margin, unsigned
    always_comb begin
        for (int a = 0; a < `NUM_AXES; a++) begin
            exceed[a]  = {2'b00, fb_q[a]} > ({1'b0, cur_cmd[a], 1'b0} + {2'b00, `SAFETY_MARGIN});
            dis_set[a] = exceed[a] && (exceed_cnt[a] == HOLD_W'(`SAFETY_HOLD - 1));
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int a = 0; a < `NUM_AXES; a++)
                exceed_cnt[a] <= '0;
            amp_disable <= 4'd0;
        end else begin
            for (int a = 0; a < `NUM_AXES; a++) begin
                if (!exceed[a])
                    exceed_cnt[a] <= '0;                // run broken
                else if (!dis_set[a])
                    exceed_cnt[a] <= exceed_cnt[a] + 1'b1;
                if (dis_clr[a])
                    amp_disable[a] <= 1'b0;             // clear wins
                else if (dis_set[a])
                    amp_disable[a] <= 1'b1;
            end
        end
    end

    // -----------------------------------------------------------------------
    // main-space read mux
    assign rd_axis    = 2'(raddr.main.chan - 4'd1);
    assign rd_axis_ok = (raddr.main.chan >= 4'd1) && (raddr.main.chan <= 4'(`NUM_AXES));

    always_comb begin
        rdata = 32'd0;                                  // unused offsets
        if (raddr.main.chan == 4'd0) begin
            if (raddr.main.offset == `OFF_STATUS)
                rdata = {28'd0, amp_disable};
        end else if (rd_axis_ok) begin
            if (raddr.main.offset == `OFF_ADC_DATA)
                rdata = {fb_q[rd_axis], cur_cmd[rd_axis]};
            else if (raddr.main.offset == `OFF_DAC_CTRL)
                rdata = {16'd0, cur_cmd[rd_axis]};
        end
    end

    // a quiet cycle means no latch before a full run of exceeding cycles
    for (genvar a = 0; a < `NUM_AXES; a++) begin : g_hold_check
        a_hold_before_set: assert property (
            @(posedge sysclk) disable iff (reset)
            (!exceed[a] && !amp_disable[a]) |-> ##(`SAFETY_HOLD) !amp_disable[a]
        ) else $error("amp disable set before a full hold run");
    end

endmodule

`default_nettype wire

//--- source/board_bus.sv
// board register bus, top level
// write arbitration, read-address override and read decode by space
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module board_bus (
    input  wire logic                sysclk,
    input  wire logic                reset,
    input  wire qla_pkg::wr_bus_t    fw_wr,
    input  wire qla_pkg::wr_bus_t    eth_wr,
    input  wire logic                eth_write_en,  // ethernet owns write bus
    input  wire qla_pkg::reg_addr_u  fw_raddr,
    input  wire qla_pkg::reg_addr_u  eth_raddr,
    input  wire logic                eth_read_en,   // ethernet owns read address
    input  wire qla_pkg::rt_wr_t     rt_wr,
    input  wire logic                sample_start,
    input  wire qla_pkg::axis_word_t cur_fb,
    output logic [31:0]              reg_rdata,
    output logic                     sample_busy,
    output qla_pkg::axis_word_t      cur_cmd,
    output logic [3:0]               amp_disable
);

    qla_pkg::wr_bus_t   bw_wr;          // from real-time writer
    qla_pkg::wr_bus_t   reg_wr;         // arbitrated write bus
    qla_pkg::reg_addr_u sample_raddr;
    qla_pkg::reg_addr_u reg_raddr;      // selected read address
    logic               bw_active;
    logic [31:0]        main_rdata;
    logic [31:0]        sample_rdata;

    // ---------------------------------------------------------------------------
    // bus ownership, rt writer > ethernet > firewire for writes
    always_comb begin
        if (bw_active)
            reg_wr = bw_wr;
        else if (eth_write_en)
            reg_wr = eth_wr;
        else
            reg_wr = fw_wr;
    end

    // sampler > ethernet > firewire for reads
    assign reg_raddr = sample_busy ? sample_raddr :
                       eth_read_en ? eth_raddr    :
                       fw_raddr;

    // read data by space, same cycle as address
    always_comb begin
        case (reg_raddr.main.space)
            `ADDR_MAIN:   reg_rdata = main_rdata;
            `ADDR_SAMPLE: reg_rdata = sample_rdata;
            default:      reg_rdata = 32'd0;
        endcase
    end

    // ---------------------------------------------------------------------------
    rt_block_writer u_rt_block_writer (
        .sysclk    (sysclk),
        .reset     (reset),
        .rt_wr     (rt_wr),
        .bw_active (bw_active),
        .bw_wr     (bw_wr)
    );

    sample_sequencer u_sample_sequencer (
        .sysclk       (sysclk),
        .reset        (reset),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .sample_raddr (sample_raddr),
        .reg_rdata    (reg_rdata),
        .buf_index    (reg_raddr.mem.index[4:0]),   // memory view
        .buf_rdata    (sample_rdata)
    );

    axis_regs u_axis_regs (
        .sysclk      (sysclk),
        .reset       (reset),
        .wr          (reg_wr),
        .raddr       (reg_raddr),
        .rdata       (main_rdata),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable)
    );

endmodule

`default_nettype wire

//--- tb/board_bus_tb.sv
// testbench for the board register bus
// random host, real-time, safety and sampling traffic checked against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module board_bus_tb;

    localparam int MAX_CYCLES = 20000;      // the tests need under a thousand cycles

    logic                sysclk;
    logic                reset;
    qla_pkg::wr_bus_t    fw_wr;
    qla_pkg::wr_bus_t    eth_wr;
    logic                eth_write_en;
    qla_pkg::reg_addr_u  fw_raddr;
    qla_pkg::reg_addr_u  eth_raddr;
    logic                eth_read_en;
    qla_pkg::rt_wr_t     rt_wr;
    logic                sample_start;
    qla_pkg::axis_word_t cur_fb;
    logic [31:0]         reg_rdata;
    logic                sample_busy;
    qla_pkg::axis_word_t cur_cmd;
    logic [3:0]          amp_disable;

    // reference model state
    logic [15:0] m_cmd  [`NUM_AXES];
    logic [15:0] m_fb   [`NUM_AXES];        // feedback as driven, read a cycle later
    logic [3:0]  m_dis;
    logic [31:0] m_sbuf [`SAMPLE_WORDS];
    int          ts_base;                   // edge the timestamp counts from
    int          edge_cnt = 0;              // posedges so far, also the timeout
    int          errors = 0;
    int          checks = 0;
    int          test_mark = 0;

    // test scratch
    logic [15:0] staged [`NUM_AXES];
    logic [3:0]  mask;
    logic        above;
    int          a_sel;
    int          thr;
    int          run;
    int          start_edge;
    int          busy_cycles;
    logic [3:0]  space;

    board_bus u_board_bus (
        .sysclk       (sysclk),
        .reset        (reset),
        .fw_wr        (fw_wr),
        .eth_wr       (eth_wr),
        .eth_write_en (eth_write_en),
        .fw_raddr     (fw_raddr),
        .eth_raddr    (eth_raddr),
        .eth_read_en  (eth_read_en),
        .rt_wr        (rt_wr),
        .sample_start (sample_start),
        .cur_fb       (cur_fb),
        .reg_rdata    (reg_rdata),
        .sample_busy  (sample_busy),
        .cur_cmd      (cur_cmd),
        .amp_disable  (amp_disable)
    );

    always #5 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic qla_pkg::reg_addr_u make_addr(input logic [3:0] sp, input logic [3:0] chan,
                                                     input logic [3:0] offset);
        qla_pkg::reg_addr_u a;
        a             = '0;
        a.main.space  = sp;
        a.main.chan   = chan;
        a.main.offset = offset;
        return a;
    endfunction

    function automatic qla_pkg::wr_bus_t random_dac_write();
        qla_pkg::wr_bus_t w;
        w       = '0;
        w.wen   = ($urandom_range(0, 3) != 0);
        w.waddr = make_addr(`ADDR_MAIN, 4'($urandom_range(1, `NUM_AXES)), `OFF_DAC_CTRL);
        w.wdata = $urandom();
        return w;
    endfunction

    // model side of a register write
    task automatic apply_write(input qla_pkg::wr_bus_t w);
        int ch;
        ch = int'(w.waddr.main.chan);
        if (w.wen && w.waddr.main.space == `ADDR_MAIN) begin
            if (ch >= 1 && ch <= `NUM_AXES && w.waddr.main.offset == `OFF_DAC_CTRL)
                m_cmd[ch - 1] = w.wdata[15:0];
            if (ch == 0 && w.waddr.main.offset == `OFF_STATUS)
                m_dis = m_dis & ~w.wdata[3:0];      // clear by mask
        end
    endtask

    // expected read data by space, channel and offset
    function automatic logic [31:0] model_read(input qla_pkg::reg_addr_u a);
        int ch;
        int idx;
        ch  = int'(a.main.chan);
        idx = int'(a.mem.index[4:0]);
        if (a.main.space == `ADDR_SAMPLE)
            return (idx < `SAMPLE_WORDS) ? m_sbuf[idx] : 32'd0;
        if (a.main.space != `ADDR_MAIN)
            return 32'd0;
        if (ch == 0)
            return (a.main.offset == `OFF_STATUS) ? {28'd0, m_dis} : 32'd0;
        if (ch > `NUM_AXES)
            return 32'd0;
        if (a.main.offset == `OFF_ADC_DATA)
            return {m_fb[ch - 1], m_cmd[ch - 1]};
        if (a.main.offset == `OFF_DAC_CTRL)
            return {16'd0, m_cmd[ch - 1]};
        return 32'd0;
    endfunction

    task automatic write_reg(input logic use_eth, input logic [3:0] chan,
                             input logic [3:0] offset, input logic [31:0] data);
        qla_pkg::wr_bus_t w;
        w       = '0;
        w.wen   = 1'b1;
        w.waddr = make_addr(`ADDR_MAIN, chan, offset);
        w.wdata = data;
        @(negedge sysclk);
        eth_write_en = use_eth;
        if (use_eth)
            eth_wr = w;
        else
            fw_wr = w;
        apply_write(w);
        @(negedge sysclk);
        fw_wr.wen  = 1'b0;
        eth_wr.wen = 1'b0;
    endtask

    // the port not under test carries a random address
    task automatic read_check(input logic use_eth, input qla_pkg::reg_addr_u addr,
                              input string what);
        @(negedge sysclk);
        eth_read_en = use_eth;
        if (use_eth) begin
            eth_raddr = addr;
            fw_raddr  = qla_pkg::reg_addr_u'(16'($urandom()));
        end else begin
            fw_raddr  = addr;
            eth_raddr = qla_pkg::reg_addr_u'(16'($urandom()));
        end
        #1;
        check_eq(reg_rdata, model_read(addr), what);
    endtask

    task automatic apply_reset();
        @(negedge sysclk);
        reset = 1'b1;
        repeat (16) @(negedge sysclk);
        reset   = 1'b0;
        ts_base = edge_cnt + 1;                     // first edge out of reset
        m_dis   = 4'd0;
        for (int a = 0; a < `NUM_AXES; a++)
            m_cmd[a] = 16'd0;
        for (int i = 0; i < `SAMPLE_WORDS; i++)
            m_sbuf[i] = 32'd0;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, errors - test_mark);
        test_mark = errors;
    endtask

    // ------------------------------------------------------------------------
    initial begin
        sysclk       = 1'b0;
        reset        = 1'b1;
        fw_wr        = '0;
        eth_wr       = '0;
        eth_write_en = 1'b0;
        fw_raddr     = '0;
        eth_raddr    = '0;
        eth_read_en  = 1'b0;
        rt_wr        = '0;
        sample_start = 1'b0;
        cur_fb       = '0;
        for (int a = 0; a < `NUM_AXES; a++)
            m_fb[a] = 16'd0;
        void'($urandom(28));
        apply_reset();

        // host writes, both ports, collisions resolved toward ethernet
        for (int i = 0; i < 60; i++) begin
            @(negedge sysclk);
            fw_wr        = random_dac_write();
            eth_wr       = random_dac_write();
            eth_write_en = 1'($urandom_range(0, 1));
            apply_write(eth_write_en ? eth_wr : fw_wr);
        end
        @(negedge sysclk);
        fw_wr.wen  = 1'b0;
        eth_wr.wen = 1'b0;
        for (int a = 0; a < `NUM_AXES; a++) begin
            read_check(1'b0, make_addr(`ADDR_MAIN, 4'(a + 1), `OFF_DAC_CTRL), "fw cmd readback");
            read_check(1'b1, make_addr(`ADDR_MAIN, 4'(a + 1), `OFF_ADC_DATA), "eth adc readback");
            check_eq({16'd0, cur_cmd[a]}, {16'd0, m_cmd[a]}, "cur_cmd after host writes");
        end
        end_test("host access and priority");

        // real-time block write
        for (int t = 0; t < 8; t++) begin
            for (int q = 0; q < `NUM_AXES; q++) begin
                @(negedge sysclk);
                rt_wr.wen   = 1'b1;
                rt_wr.waddr = 3'(q);
                rt_wr.wdata = $urandom();
                staged[q]   = rt_wr.wdata[15:0];
            end
            @(negedge sysclk);
            rt_wr.waddr = `RT_LAST_ADDR;
            rt_wr.wdata = $urandom();
            mask        = rt_wr.wdata[3:0];
            @(negedge sysclk);
            rt_wr.wen = 1'b0;
            repeat (4) @(negedge sysclk);               // one write-out cycle per axis
            for (int a = 0; a < `NUM_AXES; a++) begin
                if (mask[a])
                    m_cmd[a] = staged[a];
                check_eq({16'd0, cur_cmd[a]}, {16'd0, m_cmd[a]}, "cur_cmd after block write");
                read_check(1'($urandom_range(0, 1)),
                           make_addr(`ADDR_MAIN, 4'(a + 1), `OFF_DAC_CTRL), "block write readback");
            end
        end
        end_test("real-time block write");

        // safety latch, feedback held above or below 2*cmd + margin
        for (int t = 0; t < 12; t++) begin
            a_sel = $urandom_range(0, `NUM_AXES - 1);
            write_reg(1'b0, 4'(a_sel + 1), `OFF_DAC_CTRL, 32'($urandom_range(0, 16'h6fff)));
            thr   = 2 * int'(m_cmd[a_sel]) + int'(`SAFETY_MARGIN);
            above = 1'($urandom_range(0, 1));
            run   = 0;
            cur_fb[a_sel] = above ? 16'(thr + 1 + $urandom_range(0, 65534 - thr))
                                  : 16'($urandom_range(0, thr));
            m_fb[a_sel] = cur_fb[a_sel];
            @(posedge sysclk);                          // feedback registered
            repeat (`SAFETY_HOLD + 1) begin
                @(posedge sysclk);
                if (above)
                    run++;
                if (run >= `SAFETY_HOLD)
                    m_dis[a_sel] = 1'b1;
                @(negedge sysclk);
                check_eq({28'd0, amp_disable}, {28'd0, m_dis}, "amp_disable during hold");
            end
            cur_fb[a_sel] = 16'd0;
            m_fb[a_sel]   = 16'd0;
            repeat (2) @(negedge sysclk);
            read_check(1'($urandom_range(0, 1)), make_addr(`ADDR_MAIN, 4'd0, `OFF_STATUS),
                       "status read");
            write_reg(1'b1, 4'd0, `OFF_STATUS, {28'd0, m_dis});
            check_eq({28'd0, amp_disable}, {28'd0, m_dis}, "amp_disable after clear");
        end
        end_test("safety latch");

        // sampling bursts, with a start during the burst that must be ignored
        for (int r = 0; r < 3; r++) begin
            repeat ($urandom_range(1, 40)) @(negedge sysclk);
            for (int a = 0; a < `NUM_AXES; a++) begin
                cur_fb[a] = 16'($urandom_range(0, `SAFETY_MARGIN));   // stays below threshold
                m_fb[a]   = cur_fb[a];
            end
            repeat (2) @(negedge sysclk);
            sample_start = 1'b1;
            start_edge   = edge_cnt + 1;
            m_sbuf[0]    = 32'(start_edge - ts_base);
            ts_base      = start_edge;
            for (int a = 0; a < `NUM_AXES; a++)
                m_sbuf[a + 1] = {m_fb[a], m_cmd[a]};
            m_sbuf[`NUM_AXES + 1] = {28'd0, m_dis};
            @(negedge sysclk);
            busy_cycles = 0;
            while (sample_busy && busy_cycles <= `SAMPLE_WORDS) begin
                busy_cycles++;
                sample_start = (busy_cycles == 2);
                @(negedge sysclk);
            end
            sample_start = 1'b0;
            check_eq(32'(busy_cycles), 32'(`SAMPLE_WORDS), "sample_busy length");
            for (int i = 0; i < 32; i++)
                read_check(1'($urandom_range(0, 1)), make_addr(`ADDR_SAMPLE, 4'(i >> 4), 4'(i)),
                           "sample buffer entry");
        end
        end_test("sampling");

        // reset values, then random addresses across all spaces
        apply_reset();
        for (int a = 0; a < `NUM_AXES; a++)
            check_eq({16'd0, cur_cmd[a]}, 32'd0, "cur_cmd after reset");
        check_eq({28'd0, amp_disable}, 32'd0, "amp_disable after reset");
        check_eq({31'd0, sample_busy}, 32'd0, "sample_busy after reset");
        for (int i = 0; i < 32; i++)
            read_check(1'b0, make_addr(`ADDR_SAMPLE, 4'(i >> 4), 4'(i)), "sample entry after reset");
        for (int a = 0; a < `NUM_AXES; a++)
            write_reg(1'($urandom_range(0, 1)), 4'(a + 1), `OFF_DAC_CTRL, $urandom());
        for (int i = 0; i < 60; i++) begin
            case ($urandom_range(0, 2))
                0:       space = `ADDR_MAIN;
                1:       space = `ADDR_SAMPLE;
                default: space = 4'($urandom_range(0, 15));
            endcase
            read_check(1'($urandom_range(0, 1)), make_addr(space, 4'($urandom_range(0, 15)),
                       4'($urandom_range(0, 15))), "random address read");
        end
        end_test("reset and unmapped reads");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/qla_pkg.sv
source/timestamp_counter.sv
source/rt_block_writer.sv
source/sample_sequencer.sv
source/axis_regs.sv
source/board_bus.sv
tb/board_bus_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the board bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module board_bus_tb -o board_bus_tb

out=$(./obj_dir/board_bus_tb)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
